/* files.f */
+incdir+design
+incdir+sim
design/pll_ctrl_pkg.sv
design/pll_cfg_regs.sv
design/pll_lock_ctrl.sv
design/ssc_modulator.sv
design/post_divider.sv
design/pll_ctrl_top.sv
sim/tb_pll_ctrl.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_pll_ctrl
FILELIST  = files.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = All checks passed

.PHONY: sim clean

# Build, run, then decide on the log contents
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim/tb_pll_ctrl_model.svh */
`ifndef TB_PLL_CTRL_MODEL_SVH
`define TB_PLL_CTRL_MODEL_SVH

// ============================================================
// Error counters and random source
// ============================================================
int err_data  = 0;
int err_word  = 0;
int err_bit   = 0;
int err_count = 0;

logic [31:0] rng_state = 32'h4f32cd93;

function automatic logic [31:0] rand32();
  rng_state = rng_state * 32'd1664525 + 32'd1013904223;  // Plain LCG
  return rng_state;
endfunction

// ============================================================
// Reference rules
// ============================================================
// Bits that a register keeps, everything else reads 0
function automatic apb_data_t reg_mask(input apb_addr_t addr);
  case (addr)
    `PLL_REG_CTRL: return 32'h0000_000F;
    `PLL_REG_MUL:  return 32'h0FFF_07FF;   // int 10..0, frac 27..16
    `PLL_REG_SSC:  return 32'h07FF_00FF;   // step 7..0, period 26..16
    `PLL_REG_LDET: return 32'h0000_001F;
    `PLL_REG_PS0,
    `PLL_REG_PS1:  return 32'h0000_FF03;
    default:       return 32'h0;
  endcase
endfunction

// Restart edge to locked, base time shifted plus one
function automatic lock_count_t lock_delay(input lock_sel_t sel);
  return (lock_count_t'(`PLL_LOCK_BASE) << sel) + 1'b1;
endfunction

// Cycles between ticks, L2 of 0 counts as 1
function automatic lock_count_t tick_period(input l1_sel_t l1, input l2_div_t l2);
  lock_count_t l2_eff;
  l2_eff = (l2 == 0) ? lock_count_t'(1) : lock_count_t'(l2);
  return (lock_count_t'(1) << l1) * l2_eff;
endfunction

// Integer, fraction, padding, no spread
function automatic mult_word_t unmod_word(input mul_int_t mi, input mul_frac_t mf,
                                          input logic imode);
  mult_word_t w;
  w = mult_word_t'(mi) << ($bits(mul_frac_t) + `PLL_SSC_FRAC_SHIFT);
  if (!imode) begin
    w = w | (mult_word_t'(mf) << `PLL_SSC_FRAC_SHIFT);
  end
  return w;
endfunction

// Triangle ramp state
logic        m_dir_up;
ssc_period_t m_step_cnt;
ssc_accum_t  m_accum;

task automatic ssc_model_clear();
  m_dir_up   = 1'b1;
  m_step_cnt = ssc_period_t'(1);
  m_accum    = '0;
endtask

// One active reference cycle of the ramp
task automatic ssc_advance(input ssc_step_t step, input ssc_period_t period);
  if (m_dir_up) begin
    m_accum = m_accum + ssc_accum_t'(step);
  end else begin
    m_accum = m_accum - ssc_accum_t'(step);
  end
  if (m_step_cnt == period) begin
    m_dir_up   = ~m_dir_up;              // Turn after the full half ramp
    m_step_cnt = ssc_period_t'(1);
  end else begin
    m_step_cnt = m_step_cnt + 1'b1;
  end
endtask

// ============================================================
// Compare tasks
// ============================================================
task automatic check_data(input apb_data_t got, input apb_data_t exp, input string what);
  if (got !== exp) begin
    err_data++;
    $display("ERR %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
  end
endtask

task automatic check_word(input mult_word_t got, input mult_word_t exp, input string what);
  if (got !== exp) begin
    err_word++;
    $display("ERR %0t: %s is 0x%07h, expected 0x%07h", $time, what, got, exp);
  end
endtask

task automatic check_bit(input logic got, input logic exp, input string what);
  if (got !== exp) begin
    err_bit++;
    $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
  end
endtask

task automatic check_count(input lock_count_t got, input lock_count_t exp, input string what);
  if (got !== exp) begin
    err_count++;
    $display("ERR %0t: %s is %0d cycles, expected %0d", $time, what, got, exp);
  end
endtask

`endif

/* sim/tb_pll_ctrl.sv */
`include "pll_ctrl_macros.svh"

module tb_pll_ctrl;
  import pll_ctrl_pkg::*;

  localparam int CLK_PERIOD     = 10;
  localparam int STARTUP_CYCLES = 1 << `PLL_STARTUP_BIT;
  localparam int LOCK_ROUNDS    = 3;
  localparam int SSC_ROUNDS     = 3;
  localparam int SSC_CYCLES     = 300;
  localparam int PS_ROUNDS      = 4;

  // Worst case length of each sequence, in cycles
  localparam int LEN_START = 3 + STARTUP_CYCLES + 200;
  localparam int LEN_REGS  = 2000;
  localparam int LEN_LOCK  = LOCK_ROUNDS * 16500 + 1000;  // Longest lock is 128 << 7
  localparam int LEN_SSC   = SSC_ROUNDS * (SSC_CYCLES + 400);
  localparam int LEN_PS    = PS_ROUNDS * (3 * 2040 + 200);
  localparam int WATCHDOG_CYCLES = LEN_START + LEN_REGS + LEN_LOCK + LEN_SSC + LEN_PS + 2000;

  logic       clk_ref = 1'b0;
  logic       int_rst_n;
  logic       psel;
  logic       penable;
  logic       pwrite;
  apb_addr_t  paddr;
  apb_data_t  pwdata;
  apb_data_t  prdata;
  logic       pready;
  logic       pslverr;
  logic       locked;
  mult_word_t mult_word;
  logic       ps0_tick;
  logic       ps1_tick;
  int         cyc;        // Edges since reset release
  int         read_cyc;   // cyc when the last read was sampled

  `include "tb_pll_ctrl_model.svh"

  pll_ctrl_top DUT (.*);

  always #(CLK_PERIOD / 2) clk_ref = ~clk_ref;

  always @(posedge clk_ref) begin
    if (!int_rst_n) begin
      cyc <= 0;
    end else begin
      cyc <= cyc + 1;
    end
  end

  // ============================================================
  // APB master
  // ============================================================
  task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
    @(posedge clk_ref);
    psel    <= 1'b1;                       // Setup phase
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk_ref);
    penable <= 1'b1;                       // Access phase
    @(negedge clk_ref);
    err = pslverr;
    @(posedge clk_ref);                    // Register updates here
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
    @(posedge clk_ref);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge clk_ref);
    penable <= 1'b1;
    @(negedge clk_ref);
    data     = prdata;                     // Valid mid access phase
    err      = pslverr;
    read_cyc = cyc;
    @(posedge clk_ref);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic write_reg(input apb_addr_t addr, input apb_data_t data);
    logic err;
    apb_write(addr, data, err);
    check_bit(err, 1'b0, "pslverr on write");
  endtask

  task automatic read_reg(input apb_addr_t addr, output apb_data_t data);
    logic err;
    apb_read(addr, data, err);
    check_bit(err, 1'b0, "pslverr on read");
  endtask

  // Interval since last tick, flags early, late and missing ticks
  task automatic track_tick(input logic tick, input lock_count_t period,
                            inout lock_count_t since, input string name);
    if (tick) begin
      check_count(since, period, {name, " tick interval"});
      since = '0;
    end else if (since == period) begin
      err_bit++;
      $display("ERR %0t: %s tick missing after %0d cycles", $time, name, period);
      since = '0;
    end
    since = since + 1'b1;
  endtask

  task automatic print_error_counts();
    $display("Errors: data %0d, word %0d, bit %0d, count %0d",
             err_data, err_word, err_bit, err_count);
  endtask

  // ============================================================
  // Watchdog
  // ============================================================
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    print_error_counts();
    $display("Checks failed");
    $finish;
  end

  // ============================================================
  // Test sequences
  // ============================================================
  initial begin
    apb_data_t   rd;
    apb_data_t   wd;
    apb_data_t   shadow [6];
    apb_addr_t   addr;
    logic        err;
    logic        imode;
    lock_sel_t   sel;
    int          start;
    int          span;
    mul_int_t    mi;
    mul_frac_t   mf;
    ssc_step_t   step;
    ssc_period_t period;
    mult_word_t  base;
    l1_sel_t     l1a;
    l1_sel_t     l1b;
    l2_div_t     l2a;
    l2_div_t     l2b;
    lock_count_t rp0;
    lock_count_t rp1;
    lock_count_t since0;
    lock_count_t since1;

    int_rst_n = 1'b0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    repeat (3) @(posedge clk_ref);
    int_rst_n <= 1'b1;
    @(negedge clk_ref);
    check_bit(locked, 1'b0, "locked after reset");
    check_bit(ps0_tick, 1'b0, "ps0_tick after reset");
    check_bit(ps1_tick, 1'b0, "ps1_tick after reset");
    check_bit(pslverr, 1'b0, "pslverr after reset");
    check_bit(pready, 1'b1, "pready");

    // Startup poll, then first lock with lock_sel at reset value
    rd = '0;
    while (!rd[0]) begin
      read_reg(`PLL_REG_STATUS, rd);
      check_bit(rd[0], read_cyc >= STARTUP_CYCLES, "STATUS running");
      check_bit(rd[1], read_cyc >= STARTUP_CYCLES + lock_delay('0), "STATUS raw lock");
    end
    do @(negedge clk_ref); while (!locked);
    check_count(lock_count_t'(cyc - STARTUP_CYCLES), lock_delay('0), "first lock delay");

    // Register readback
    for (int r = 0; r < 4; r++) begin
      for (int i = 0; i < 6; i++) begin
        wd = rand32();
        write_reg(apb_addr_t'(4 * i), wd);
        shadow[i] = wd & reg_mask(apb_addr_t'(4 * i));
      end
      for (int i = 0; i < 6; i++) begin
        read_reg(apb_addr_t'(4 * i), rd);
        check_data(rd, shadow[i], "register readback");
      end
    end
    addr = apb_addr_t'(32'h1C + rand32() % 228);   // Anywhere past STATUS
    apb_write(addr, rand32(), err);
    check_bit(err, 1'b1, "pslverr on unmapped write");
    apb_read(addr, rd, err);
    check_bit(err, 1'b1, "pslverr on unmapped read");
    check_data(rd, '0, "unmapped read data");
    apb_write(`PLL_REG_STATUS, 32'hFFFF_FFFF, err);
    check_bit(err, 1'b1, "pslverr on STATUS write");
    for (int i = 0; i < 6; i++) begin
      read_reg(apb_addr_t'(4 * i), rd);
      check_data(rd, shadow[i], "register after error access");
    end

    // Lock time, restart on MUL write
    for (int r = 0; r < LOCK_ROUNDS; r++) begin
      sel = lock_sel_t'(rand32());
      write_reg(`PLL_REG_LDET, apb_data_t'(sel) | 32'h8);   // lock_en on, no force
      write_reg(`PLL_REG_MUL, rand32());
      @(negedge clk_ref);
      start = cyc;
      check_bit(locked, 1'b0, "locked after MUL write");
      while (!locked) @(negedge clk_ref);
      check_count(lock_count_t'(cyc - start), lock_delay(sel), "lock delay");
      read_reg(`PLL_REG_STATUS, rd);
      check_bit(rd[1], 1'b1, "STATUS raw lock when locked");
    end
    write_reg(`PLL_REG_LDET, apb_data_t'(sel));             // Mask off
    @(negedge clk_ref);
    check_bit(locked, 1'b0, "locked with lock_en clear");
    read_reg(`PLL_REG_STATUS, rd);
    check_bit(rd[1], 1'b1, "STATUS raw lock with lock_en clear");
    write_reg(`PLL_REG_LDET, apb_data_t'(sel) | 32'h10);    // Force only
    @(negedge clk_ref);
    check_bit(locked, 1'b1, "locked with lock_force");
    write_reg(`PLL_REG_MUL, rand32());
    @(negedge clk_ref);
    check_bit(locked, 1'b1, "forced lock across relock");
    read_reg(`PLL_REG_STATUS, rd);
    check_bit(rd[1], 1'b0, "STATUS raw lock after MUL write");
    write_reg(`PLL_REG_LDET, 32'h8);
    @(negedge clk_ref);
    check_bit(locked, 1'b0, "locked after force release");

    // Spread spectrum against the ramp model
    for (int r = 0; r < SSC_ROUNDS; r++) begin
      wd     = rand32();
      imode  = wd[0];
      mi     = mul_int_t'(rand32());
      mf     = mul_frac_t'(rand32());
      step   = ssc_step_t'(rand32());
      period = ssc_period_t'(1 + rand32() % 60);
      base   = unmod_word(mi, mf, imode);
      write_reg(`PLL_REG_LDET, 32'h8);                      // Shortest lock
      write_reg(`PLL_REG_CTRL, apb_data_t'(imode));         // SSC off
      write_reg(`PLL_REG_MUL, (apb_data_t'(mf) << `PLL_MUL_FRAC_LSB) | apb_data_t'(mi));
      write_reg(`PLL_REG_SSC, (apb_data_t'(period) << `PLL_SSC_PERIOD_LSB) | apb_data_t'(step));
      do begin
        @(negedge clk_ref);
        check_word(mult_word, base, "word with SSC off");
      end while (!locked);
      write_reg(`PLL_REG_CTRL, apb_data_t'(imode) | 32'h2);
      ssc_model_clear();
      repeat (SSC_CYCLES) begin
        @(negedge clk_ref);
        check_word(mult_word, base + mult_word_t'(m_accum), "modulated word");
        ssc_advance(step, period);
      end
      write_reg(`PLL_REG_CTRL, apb_data_t'(imode));
      @(posedge clk_ref);                                   // Ramp clears here
      repeat (4) begin
        @(negedge clk_ref);
        check_word(mult_word, base, "word after SSC off");
      end
    end

    // Postscalers
    for (int r = 0; r < PS_ROUNDS; r++) begin
      write_reg(`PLL_REG_CTRL, 32'h0);
      l1a = l1_sel_t'(rand32());
      l1b = l1_sel_t'(rand32());
      l2a = (r == 0) ? l2_div_t'(0) : l2_div_t'(rand32());
      l2b = (r == 1) ? l2_div_t'(0) : l2_div_t'(rand32());
      write_reg(`PLL_REG_PS0, (apb_data_t'(l2a) << `PLL_PS_L2_LSB) | apb_data_t'(l1a));
      write_reg(`PLL_REG_PS1, (apb_data_t'(l2b) << `PLL_PS_L2_LSB) | apb_data_t'(l1b));
      repeat (16) begin
        @(negedge clk_ref);
        check_bit(ps0_tick, 1'b0, "ps0_tick while disabled");
        check_bit(ps1_tick, 1'b0, "ps1_tick while disabled");
      end
      rp0  = tick_period(l1a, l2a);
      rp1  = tick_period(l1b, l2b);
      span = 3 * ((rp0 > rp1) ? rp0 : rp1) + 4;
      write_reg(`PLL_REG_CTRL, 32'hC);                      // Both on
      since0 = '0;
      since1 = '0;
      repeat (span) begin
        @(negedge clk_ref);
        track_tick(ps0_tick, rp0, since0, "ps0");
        track_tick(ps1_tick, rp1, since1, "ps1");
      end
    end

    print_error_counts();
    if (err_data + err_word + err_bit + err_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* design/pll_ctrl_top.sv */
module pll_ctrl_top (
  input  logic                     clk_ref,
  input  logic                     int_rst_n,
  input  logic                     psel,
  input  logic                     penable,
  input  logic                     pwrite,
  input  pll_ctrl_pkg::apb_addr_t  paddr,
  input  pll_ctrl_pkg::apb_data_t  pwdata,
  output pll_ctrl_pkg::apb_data_t  prdata,
  output logic                     pready,
  output logic                     pslverr,
  output logic                     locked,
  output pll_ctrl_pkg::mult_word_t mult_word,
  output logic                     ps0_tick,
  output logic                     ps1_tick
);
  import pll_ctrl_pkg::*;

  // Register fields
  logic        integer_mode;
  logic        ssc_en;
  mul_int_t    mul_int;
  mul_frac_t   mul_frac;
  ssc_step_t   ssc_step;
  ssc_period_t ssc_period;
  lock_sel_t   lock_sel;
  logic        ps0_en;
  l1_sel_t     ps0_l1;
  l2_div_t     ps0_l2;
  logic        ps1_en;
  l1_sel_t     ps1_l1;
  l2_div_t     ps1_l2;
  logic        mul_write;   // MUL written, relock
  logic        running;     // Calibration done
  logic        lock_raw;

  // ============================================================
  // Register block, lock control, modulator
  // ============================================================
  pll_cfg_regs u_regs (
    .clk_ref, .int_rst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
    .running, .lock_raw, .prdata, .pready, .pslverr,
    .integer_mode, .ssc_en, .mul_int, .mul_frac, .ssc_step, .ssc_period,
    .lock_sel, .lock_en (), .lock_force (),   // Only used for locked inside
    .ps0_en, .ps0_l1, .ps0_l2, .ps1_en, .ps1_l1, .ps1_l2,
    .mul_write, .locked
  );

  pll_lock_ctrl u_lock (
    .clk_ref, .int_rst_n, .lock_sel, .mul_write, .running, .lock_raw
  );

  ssc_modulator u_ssc (
    .clk_ref, .int_rst_n, .ssc_en, .lock_raw, .integer_mode,
    .mul_int, .mul_frac, .ssc_step, .ssc_period, .mult_word
  );

  // ============================================================
  // Postscalers
  // ============================================================
  post_divider u_ps0 (
    .clk_ref, .int_rst_n, .enable (ps0_en), .running,
    .l1 (ps0_l1), .l2 (ps0_l2), .tick (ps0_tick)
  );

  post_divider u_ps1 (
    .clk_ref, .int_rst_n, .enable (ps1_en), .running,
    .l1 (ps1_l1), .l2 (ps1_l2), .tick (ps1_tick)
  );

endmodule

/* design/post_divider.sv */
`include "pll_ctrl_macros.svh"

module post_divider (
  input  logic                  clk_ref,
  input  logic                  int_rst_n,
  input  logic                  enable,
  input  logic                  running,
  input  pll_ctrl_pkg::l1_sel_t l1,
  input  pll_ctrl_pkg::l2_div_t l2,
  output logic                  tick
);

  logic                       active;
  logic [`PLL_L1_CNT_W-1:0]   l1_cnt;
  logic [`PLL_L1_CNT_W-1:0]   l1_mask;      // Low bits that must be all ones
  logic                       stage_pulse;  // L1 output, one per L1 ratio
  logic [`PLL_L2_CNT_W-1:0]   l2_cnt;
  logic [`PLL_L2_CNT_W-1:0]   l2_half;
  logic [`PLL_L2_CNT_W-1:0]   l2_term;
  logic                       l2_phase;     // Second half carries the odd pulse
  logic                       l2_bypass;    // Ratio 0 or 1
  logic                       tick_next;

  assign active = enable & running;

  // ============================================================
  // L1 power-of-two stage
  // ============================================================
  always_comb begin
    case (l1)
      2'd0:    l1_mask = 3'b000;   // /1
      2'd1:    l1_mask = 3'b001;   // /2
      2'd2:    l1_mask = 3'b011;   // /4
      default: l1_mask = 3'b111;   // /8
    endcase
  end

  assign stage_pulse = ((l1_cnt & l1_mask) == l1_mask);

  // L2 counted as two halves of the ratio
  assign l2_half   = l2[7:1];
  assign l2_bypass = (l2_half == '0);
  assign l2_term   = l2_phase ? (l2_half - 1'b1 + l2[0]) : (l2_half - 1'b1);
  assign tick_next = stage_pulse & (l2_bypass | (l2_phase & (l2_cnt == l2_term)));

  // ============================================================
  // Counters and tick
  // ============================================================
  always_ff @(posedge clk_ref) begin
    if (!int_rst_n || !active) begin
      l1_cnt   <= '0;                       // Cleared while off
      l2_cnt   <= '0;
      l2_phase <= 1'b0;
      tick     <= 1'b0;
    end else begin
      l1_cnt <= l1_cnt + 1'b1;              // Free running, wraps at 8
      tick   <= tick_next;
      if (stage_pulse && !l2_bypass) begin
        if (l2_cnt == l2_term) begin
          l2_cnt   <= '0;
          l2_phase <= ~l2_phase;            // Next half
        end else begin
          l2_cnt <= l2_cnt + 1'b1;
        end
      end
    end
  end

endmodule

/* design/ssc_modulator.sv */
`include "pll_ctrl_macros.svh"

module ssc_modulator (
  input  logic                      clk_ref,
  input  logic                      int_rst_n,
  input  logic                      ssc_en,
  input  logic                      lock_raw,
  input  logic                      integer_mode,
  input  pll_ctrl_pkg::mul_int_t    mul_int,
  input  pll_ctrl_pkg::mul_frac_t   mul_frac,
  input  pll_ctrl_pkg::ssc_step_t   ssc_step,
  input  pll_ctrl_pkg::ssc_period_t ssc_period,
  output pll_ctrl_pkg::mult_word_t  mult_word
);
  import pll_ctrl_pkg::*;

  logic        mod_active;   // Spread only once locked
  logic        dir_up;
  logic        period_end;
  ssc_period_t step_cnt;     // 1 .. ssc_period
  ssc_accum_t  accum;
  mul_frac_t   frac_eff;

  assign mod_active = ssc_en & lock_raw;
  assign period_end = (step_cnt == ssc_period);

  // ============================================================
  // Triangle ramp
  // ============================================================
  always_ff @(posedge clk_ref) begin
    if (!int_rst_n || !mod_active) begin
      dir_up   <= 1'b1;                     // Ramp always starts upward
      step_cnt <= ssc_period_t'(1);
      accum    <= '0;
    end else begin
      if (period_end) begin
        dir_up   <= ~dir_up;                // Turn at end of half ramp
        step_cnt <= ssc_period_t'(1);
      end else begin
        step_cnt <= step_cnt + 1'b1;
      end
      // Current direction still applies on the turning cycle
      if (dir_up) begin
        accum <= accum + ssc_accum_t'(ssc_step);
      end else begin
        accum <= accum - ssc_accum_t'(ssc_step);
      end
    end
  end

  // ============================================================
  // Multiplication word
  // ============================================================
  assign frac_eff = integer_mode ? '0 : mul_frac;  // No fraction in integer mode

  // Ratio in fixed point with padding, plus the spread offset
  assign mult_word = {mul_int, frac_eff, {`PLL_SSC_FRAC_SHIFT{1'b0}}}
                   + mult_word_t'(accum);

endmodule

/* design/pll_lock_ctrl.sv */
`include "pll_ctrl_macros.svh"

module pll_lock_ctrl (
  input  logic                    clk_ref,
  input  logic                    int_rst_n,
  input  pll_ctrl_pkg::lock_sel_t lock_sel,
  input  logic                    mul_write,
  output logic                    running,
  output logic                    lock_raw
);
  import pll_ctrl_pkg::*;

  logic [`PLL_STARTUP_BIT:0] startup_cnt;  // Top bit ends calibration
  lock_state_t               lock_state;
  lock_count_t               lock_cnt;
  lock_count_t               lock_load;

  // Base lock time scaled by 2**lock_sel
  assign lock_load = lock_count_t'(`PLL_LOCK_BASE) << lock_sel;

  // ============================================================
  // Startup calibration
  // ============================================================
  always_ff @(posedge clk_ref) begin
    if (!int_rst_n) begin
      startup_cnt <= '0;
    end else if (!startup_cnt[`PLL_STARTUP_BIT]) begin
      startup_cnt <= startup_cnt + 1'b1;    // Freezes once the top bit sets
    end
  end

  assign running = startup_cnt[`PLL_STARTUP_BIT];  // Sticky until reset

  // ============================================================
  // Lock counter
  // ============================================================
  always_ff @(posedge clk_ref) begin
    if (!int_rst_n) begin
      lock_state <= LOCK_IDLE;
      lock_cnt   <= '0;
    end else if (!running || mul_write) begin
      // New ratio or still calibrating, start over
      lock_state <= LOCK_IDLE;
      lock_cnt   <= lock_load;
    end else begin
      case (lock_state)
        LOCK_IDLE: begin
          lock_cnt   <= lock_cnt - 1'b1;    // First running cycle counts
          lock_state <= LOCK_COUNTING;
        end
        LOCK_COUNTING: begin
          if (lock_cnt == '0) begin
            lock_state <= LOCK_LOCKED;
          end else begin
            lock_cnt <= lock_cnt - 1'b1;
          end
        end
        LOCK_LOCKED: lock_state <= LOCK_LOCKED;  // Held until restart
        default:     lock_state <= LOCK_IDLE;
      endcase
    end
  end

  assign lock_raw = (lock_state == LOCK_LOCKED);

endmodule

/* design/pll_cfg_regs.sv */
`include "pll_ctrl_macros.svh"

module pll_cfg_regs (
  input  logic                      clk_ref,
  input  logic                      int_rst_n,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  pll_ctrl_pkg::apb_addr_t   paddr,
  input  pll_ctrl_pkg::apb_data_t   pwdata,
  input  logic                      running,
  input  logic                      lock_raw,
  output pll_ctrl_pkg::apb_data_t   prdata,
  output logic                      pready,
  output logic                      pslverr,
  output logic                      integer_mode,
  output logic                      ssc_en,
  output pll_ctrl_pkg::mul_int_t    mul_int,
  output pll_ctrl_pkg::mul_frac_t   mul_frac,
  output pll_ctrl_pkg::ssc_step_t   ssc_step,
  output pll_ctrl_pkg::ssc_period_t ssc_period,
  output pll_ctrl_pkg::lock_sel_t   lock_sel,
  output logic                      lock_en,
  output logic                      lock_force,
  output logic                      ps0_en,
  output pll_ctrl_pkg::l1_sel_t     ps0_l1,
  output pll_ctrl_pkg::l2_div_t     ps0_l2,
  output logic                      ps1_en,
  output pll_ctrl_pkg::l1_sel_t     ps1_l1,
  output pll_ctrl_pkg::l2_div_t     ps1_l2,
  output logic                      mul_write,
  output logic                      locked
);
  import pll_ctrl_pkg::*;

  logic      access;      // APB access phase
  logic      addr_valid;
  logic      wr_en;
  apb_data_t rdata;

  assign access  = psel & penable;
  assign pready  = 1'b1;                    // Never stalls
  assign pslverr = access & (~addr_valid | (pwrite & (paddr == `PLL_REG_STATUS)));
  assign wr_en   = access & pwrite & ~pslverr;

  assign mul_write = wr_en & (paddr == `PLL_REG_MUL);  // Restarts lock detection
  assign locked    = (lock_raw & lock_en) | lock_force;
  assign prdata    = rdata;

  // ============================================================
  // Address decode and readback
  // ============================================================
  always_comb begin
    addr_valid = 1'b1;
    rdata      = '0;                        // Unused bits read 0
    case (paddr)
      `PLL_REG_CTRL: begin
        rdata[0] = integer_mode;
        rdata[1] = ssc_en;
        rdata[2] = ps0_en;
        rdata[3] = ps1_en;
      end
      `PLL_REG_MUL: begin
        rdata[$bits(mul_int_t)-1:0]                       = mul_int;
        rdata[`PLL_MUL_FRAC_LSB +: $bits(mul_frac_t)]     = mul_frac;
      end
      `PLL_REG_SSC: begin
        rdata[$bits(ssc_step_t)-1:0]                      = ssc_step;
        rdata[`PLL_SSC_PERIOD_LSB +: $bits(ssc_period_t)] = ssc_period;
      end
      `PLL_REG_LDET: begin
        rdata[$bits(lock_sel_t)-1:0]  = lock_sel;
        rdata[`PLL_LDET_EN_BIT]       = lock_en;
        rdata[`PLL_LDET_FORCE_BIT]    = lock_force;
      end
      `PLL_REG_PS0: begin
        rdata[$bits(l1_sel_t)-1:0]                  = ps0_l1;
        rdata[`PLL_PS_L2_LSB +: $bits(l2_div_t)]    = ps0_l2;
      end
      `PLL_REG_PS1: begin
        rdata[$bits(l1_sel_t)-1:0]                  = ps1_l1;
        rdata[`PLL_PS_L2_LSB +: $bits(l2_div_t)]    = ps1_l2;
      end
      `PLL_REG_STATUS: begin
        rdata[0] = running;
        rdata[1] = lock_raw;                // Raw state, not masked by lock_en
      end
      default: addr_valid = 1'b0;           // Unmapped, error response
    endcase
  end

  // ============================================================
  // Control fields
  // ============================================================
  always_ff @(posedge clk_ref) begin
    if (!int_rst_n) begin
      integer_mode <= 1'b0;
      ssc_en       <= 1'b0;
      ps0_en       <= 1'b0;
      ps1_en       <= 1'b0;
      mul_int      <= '0;
      mul_frac     <= '0;
      ssc_step     <= '0;
      ssc_period   <= '0;
      lock_sel     <= '0;
      lock_en      <= 1'b1;                 // Lock reporting on by default
      lock_force   <= 1'b0;
      ps0_l1       <= '0;
      ps0_l2       <= '0;
      ps1_l1       <= '0;
      ps1_l2       <= '0;
    end else if (wr_en) begin
      case (paddr)
        `PLL_REG_CTRL: begin
          integer_mode <= pwdata[0];
          ssc_en       <= pwdata[1];
          ps0_en       <= pwdata[2];
          ps1_en       <= pwdata[3];
        end
        `PLL_REG_MUL: begin
          mul_int  <= pwdata[$bits(mul_int_t)-1:0];
          mul_frac <= pwdata[`PLL_MUL_FRAC_LSB +: $bits(mul_frac_t)];
        end
        `PLL_REG_SSC: begin
          ssc_step   <= pwdata[$bits(ssc_step_t)-1:0];
          ssc_period <= pwdata[`PLL_SSC_PERIOD_LSB +: $bits(ssc_period_t)];
        end
        `PLL_REG_LDET: begin
          lock_sel   <= pwdata[$bits(lock_sel_t)-1:0];
          lock_en    <= pwdata[`PLL_LDET_EN_BIT];
          lock_force <= pwdata[`PLL_LDET_FORCE_BIT];
        end
        `PLL_REG_PS0: begin
          ps0_l1 <= pwdata[$bits(l1_sel_t)-1:0];
          ps0_l2 <= pwdata[`PLL_PS_L2_LSB +: $bits(l2_div_t)];
        end
        `PLL_REG_PS1: begin
          ps1_l1 <= pwdata[$bits(l1_sel_t)-1:0];
          ps1_l2 <= pwdata[`PLL_PS_L2_LSB +: $bits(l2_div_t)];
        end
        default: ;                          // STATUS is read only
      endcase
    end
  end

endmodule

/* design/pll_ctrl_pkg.sv */
`include "pll_ctrl_macros.svh"

package pll_ctrl_pkg;

  // ============================================================
  // Multiplier and modulation widths
  // ============================================================
  typedef logic [10:0] mul_int_t;     // Integer part of the ratio
  typedef logic [11:0] mul_frac_t;    // Fractional part
  typedef logic [27:0] mult_word_t;   // Word to the oscillator
  typedef logic [7:0]  ssc_step_t;
  typedef logic [10:0] ssc_period_t;  // Ref cycles per half ramp
  typedef logic [16:0] ssc_accum_t;

  // Lock detector
  typedef logic [2:0]  lock_sel_t;    // Shift of the base lock time
  typedef logic [14:0] lock_count_t;  // Holds 128 << 7

  typedef enum logic [1:0] {
    LOCK_IDLE,                        // Counter loaded, waiting
    LOCK_COUNTING,
    LOCK_LOCKED
  } lock_state_t;

  // Postscaler ratios
  typedef logic [1:0]  l1_sel_t;      // Divide by 1, 2, 4 or 8
  typedef logic [7:0]  l2_div_t;      // 0 acts as 1

  // APB
  typedef logic [`PLL_ADDR_W-1:0] apb_addr_t;
  typedef logic [`PLL_DATA_W-1:0] apb_data_t;

endpackage

/* design/pll_ctrl_macros.svh */
`ifndef PLL_CTRL_MACROS_SVH
`define PLL_CTRL_MACROS_SVH

// ============================================================
// APB bus widths
// ============================================================
`define PLL_ADDR_W          8
`define PLL_DATA_W          32

// Register map, one 32-bit word each
`define PLL_REG_CTRL        8'h00   // Mode and output enables
`define PLL_REG_MUL         8'h04   // Integer and fractional multiplier
`define PLL_REG_SSC         8'h08   // Spread step and half period
`define PLL_REG_LDET        8'h0C   // Lock detector setup
`define PLL_REG_PS0         8'h10
`define PLL_REG_PS1         8'h14
`define PLL_REG_STATUS      8'h18   // Read only

// Field positions inside the registers
`define PLL_MUL_FRAC_LSB    16
`define PLL_SSC_PERIOD_LSB  16
`define PLL_LDET_EN_BIT     3
`define PLL_LDET_FORCE_BIT  4
`define PLL_PS_L2_LSB       8

// Counter sizes
`define PLL_STARTUP_BIT     9       // 512 cycles of calibration
`define PLL_LOCK_BASE       128     // Shortest lock time
`define PLL_SSC_FRAC_SHIFT  5       // Zero padding under the fraction
`define PLL_L1_CNT_W        3       // Up to divide by 8
`define PLL_L2_CNT_W        7       // Half of the 8-bit L2 ratio

`endif
